// File: hw/mul_pkg.sv
`default_nettype none

package mul_pkg;

	parameter int XLEN_DEF = 64;

	// one operand word seen as a doubleword or as two words
	typedef struct packed {
		logic [31:0] hi;
		logic [31:0] lo;
	} op_halves_t;

	typedef union packed {
		logic [63:0] dword;
		op_halves_t  half; // lo used by mulw and for the sign bit
	} op_word_u;

	// bit 0 multiplicand signed, bit 1 multiplier signed
	typedef logic [1:0] sign_sel_t;

	// first pipeline stage, sized for XLEN of 64
	typedef struct packed {
		logic              valid;
		logic              mulw;
		logic [32:0][131:0] pp;   // partial products, already shifted
		logic [32:0]       corr; // +1 for each negated group, weight 1
	} pp_stage_t;

	// one wallace column result
	typedef struct packed {
		logic sum;
		logic carry; // weight of the next column
	} column_out_t;

endpackage

`default_nettype wire

// File: hw/booth_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module booth_encoder #(
	parameter int XLEN = mul_pkg::XLEN_DEF
) (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                mul_valid,
	input  wire logic                flush,
	input  wire logic                mulw,
	input  wire mul_pkg::sign_sel_t  mul_signed,
	input  wire mul_pkg::op_word_u   multiplicand,
	input  wire mul_pkg::op_word_u   multiplier,
	output logic                     mul_ready,
	output mul_pkg::pp_stage_t       pp_stage
);

	import mul_pkg::*;

	localparam int PP_NUM = XLEN / 2 + 1;
	localparam int PW     = 2 * XLEN + 4;

	logic [XLEN-1:0] a_op;
	logic [XLEN-1:0] b_op;
	logic            a_sign;
	logic            b_sign;
	logic [XLEN+1:0] a_ext;
	logic [XLEN+1:0] b_ext;
	logic [XLEN+2:0] a_grp; // a_ext with the implicit zero below bit 0
	logic [PW-1:0]   b_wide;
	logic [PW-1:0]   pp_vec [PP_NUM];
	logic [PP_NUM-1:0] corr_vec;
	logic            accept;
	pp_stage_t       stage_d;
	pp_stage_t       data_q;
	logic            valid_q;

	assign accept = mul_valid & ~flush;

	// mulw only looks at the low word
	assign a_op = mulw ? XLEN'($signed(multiplicand.half.lo)) : multiplicand.dword[XLEN-1:0];
	assign b_op = mulw ? XLEN'($signed(multiplier.half.lo)) : multiplier.dword[XLEN-1:0];

	assign a_sign = mul_signed[0] & (mulw ? multiplicand.half.lo[31] : multiplicand.dword[XLEN-1]);
	assign b_sign = mul_signed[1] & (mulw ? multiplier.half.lo[31] : multiplier.dword[XLEN-1]);

	assign a_ext  = {{2{a_sign}}, a_op};
	assign b_ext  = {{2{b_sign}}, b_op};
	assign a_grp  = {a_ext, 1'b0};
	assign b_wide = PW'($signed(b_ext));

	// radix-4 recoding, one group per partial product
	for (genvar i = 0; i < PP_NUM; i++) begin : gen_group
		logic [2:0]    grp;
		logic          neg;
		logic          one;
		logic          two;
		logic [PW-1:0] mag;

		assign grp = a_grp[2*i+2 -: 3];
		assign neg = grp[2] & ~(grp[1] & grp[0]); // 100, 101, 110
		assign one = grp[1] ^ grp[0];
		assign two = (grp == 3'b011) | (grp == 3'b100);
		assign mag = one ? b_wide : (two ? (b_wide << 1) : '0);

		// ~x + 1 on the whole shifted word, the +1 rides in corr
		assign pp_vec[i]   = neg ? ~(mag << (2 * i)) : (mag << (2 * i));
		assign corr_vec[i] = neg;
	end

	always_comb begin
		stage_d      = '0;
		stage_d.mulw = mulw;
		for (int i = 0; i < PP_NUM; i++) begin
			stage_d.pp[i][PW-1:0] = pp_vec[i];
			stage_d.corr[i]       = corr_vec[i];
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			data_q <= stage_d;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q   <= 1'b0;
			mul_ready <= 1'b0;
		end else begin
			valid_q   <= accept; // flush kills stage 1 too
			mul_ready <= 1'b1;
		end
	end

	always_comb begin
		pp_stage       = data_q;
		pp_stage.valid = valid_q;
	end

	a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
		mul_ready |-> !$isunknown({mul_valid, flush}))
		else $error("mul_valid or flush unknown while ready");

endmodule

`default_nettype wire

// File: hw/csa_column.sv
`timescale 1ns/1ps
`default_nettype none

// one product bit position of the wallace tree
module csa_column #(
	parameter int XLEN = mul_pkg::XLEN_DEF
) (
	input  wire logic [XLEN/2:0]   pp_bits,   // bit k of every partial product
	input  wire logic [XLEN/2-2:0] carry_in,  // from column k-1
	output logic      [XLEN/2-2:0] carry_out, // to column k+1
	output mul_pkg::column_out_t   column
);

	localparam int PP_NUM    = XLEN / 2 + 1;
	localparam int CARRY_NUM = PP_NUM - 2;
	localparam int FA_NUM    = PP_NUM - 1;
	localparam int IN_NUM    = CARRY_NUM + PP_NUM + 1; // one zero pad
	localparam int POOL_NUM  = IN_NUM + FA_NUM;

	// bits waiting to be reduced, each adder appends its sum
	logic [POOL_NUM-1:0] pool;
	logic [FA_NUM-1:0]   fa_carry;

	// carries from column k-1 fill the first pool entries
	assign pool[CARRY_NUM-1:0]                = carry_in;
	assign pool[CARRY_NUM+PP_NUM-1:CARRY_NUM] = pp_bits;
	assign pool[IN_NUM-1]                     = 1'b0;

	/*
	 * Adder j takes pool entries 3j..3j+2 and writes its sum to
	 * entry IN_NUM+j. Taking the oldest entries first keeps the
	 * tree balanced, and the last sum left over is the column sum.
	 */
	for (genvar j = 0; j < FA_NUM; j++) begin : gen_fa
		logic a;
		logic b;
		logic c;

		assign a = pool[3*j];
		assign b = pool[3*j+1];
		assign c = pool[3*j+2];

		assign pool[IN_NUM+j] = a ^ b ^ c;
		assign fa_carry[j]    = (a & b) | (a & c) | (b & c);
	end

	assign carry_out    = fa_carry[CARRY_NUM-1:0];
	assign column.carry = fa_carry[FA_NUM-1]; // last adder
	assign column.sum   = pool[POOL_NUM-1];

endmodule

`default_nettype wire

// File: hw/product_adder.sv
`timescale 1ns/1ps
`default_nettype none

module product_adder #(
	parameter int XLEN = mul_pkg::XLEN_DEF
) (
	input  wire logic                                   clk,
	input  wire logic                                   rst_n,
	input  wire logic                                   flush,
	input  wire logic                                   stage_valid,
	input  wire logic                                   stage_mulw,
	input  wire mul_pkg::column_out_t [2*XLEN+3:0]      columns,
	input  wire logic [1:0]                             corr_hi,
	output logic                                        out_valid,
	output logic [XLEN-1:0]                             result_hi,
	output logic [XLEN-1:0]                             result_lo
);

	localparam int PW = 2 * XLEN + 4;

	logic [PW-1:0]   sum_vec;
	logic [PW-1:0]   carry_vec; // already shifted up one place
	logic [PW-1:0]   total;
	logic [XLEN-1:0] prod_hi;
	logic [XLEN-1:0] prod_lo;
	logic            load;

	always_comb begin
		carry_vec[0] = 1'b0;
		for (int k = 0; k < PW; k++) begin
			sum_vec[k] = columns[k].sum;
			if (k < PW - 1)
				carry_vec[k+1] = columns[k].carry; // top carry falls off
		end
	end

	// final carry-propagate add
	assign total = sum_vec + carry_vec + PW'(corr_hi[0]) + PW'(corr_hi[1]);

	assign prod_hi = total[2*XLEN-1:XLEN];
	assign prod_lo = stage_mulw ? XLEN'($signed(total[31:0])) : total[XLEN-1:0];

	assign load = stage_valid & ~flush;

	always_ff @(posedge clk) begin
		if (load) begin
			result_hi <= prod_hi;
			result_lo <= prod_lo; // held until the next result
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= load;
	end

	// every column must reach the output with a known value
	a_result_known: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> !$isunknown({result_hi, result_lo}))
		else $error("result unknown while out_valid is high");

endmodule

`default_nettype wire

// File: hw/booth_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module booth_multiplier #(
	parameter int XLEN = mul_pkg::XLEN_DEF
) (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic               mul_valid,
	input  wire logic               flush,
	input  wire logic               mulw,
	input  wire mul_pkg::sign_sel_t mul_signed,
	input  wire mul_pkg::op_word_u  multiplicand,
	input  wire mul_pkg::op_word_u  multiplier,
	output logic                    mul_ready,
	output logic                    out_valid,
	output logic [XLEN-1:0]         result_hi,
	output logic [XLEN-1:0]         result_lo
);

	import mul_pkg::*;

	localparam int PP_NUM    = XLEN / 2 + 1;
	localparam int PW        = 2 * XLEN + 4;
	localparam int CARRY_NUM = PP_NUM - 2;

	pp_stage_t                    pp_stage;
	logic [PP_NUM-1:0]            col_bits    [PW];
	logic [CARRY_NUM-1:0]         carry_chain [PW];
	column_out_t [PW-1:0]         columns;

	booth_encoder #(.XLEN(XLEN)) u_encoder (
		.clk          (clk),
		.rst_n        (rst_n),
		.mul_valid    (mul_valid),
		.flush        (flush),
		.mulw         (mulw),
		.mul_signed   (mul_signed),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.mul_ready    (mul_ready),
		.pp_stage     (pp_stage)
	);

	// column k gets bit k of every partial product
	always_comb begin
		for (int k = 0; k < PW; k++)
			for (int i = 0; i < PP_NUM; i++)
				col_bits[k][i] = pp_stage.pp[i][k];
	end

	assign carry_chain[0] = pp_stage.corr[CARRY_NUM-1:0]; // low corrections

	for (genvar k = 0; k < PW; k++) begin : gen_column
		if (k == PW - 1) begin : g_top
			csa_column #(.XLEN(XLEN)) u_column (
				.pp_bits   (col_bits[k]),
				.carry_in  (carry_chain[k]),
				.carry_out (),
				.column    (columns[k])
			);
		end else begin : g_mid
			csa_column #(.XLEN(XLEN)) u_column (
				.pp_bits   (col_bits[k]),
				.carry_in  (carry_chain[k]),
				.carry_out (carry_chain[k+1]),
				.column    (columns[k])
			);
		end
	end

	product_adder #(.XLEN(XLEN)) u_adder (
		.clk         (clk),
		.rst_n       (rst_n),
		.flush       (flush),
		.stage_valid (pp_stage.valid),
		.stage_mulw  (pp_stage.mulw),
		.columns     (columns),
		.corr_hi     (pp_stage.corr[PP_NUM-1:PP_NUM-2]),
		.out_valid   (out_valid),
		.result_hi   (result_hi),
		.result_lo   (result_lo)
	);

	// result comes two edges after an unflushed accept
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $past(mul_valid && !flush, 2) && !$past(flush))
		else $error("out_valid without a matching accept");

endmodule

`default_nettype wire

// File: testbench/mul_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mul_checker #(
	parameter int XLEN = mul_pkg::XLEN_DEF
) (
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire logic            mul_valid,
	input  wire logic            flush,
	input  wire logic            out_valid,
	input  wire logic [XLEN-1:0] result_hi,
	input  wire logic [XLEN-1:0] result_lo,
	input  wire logic            exp_push,
	input  wire logic [31:0]     exp_id,
	input  wire logic [XLEN-1:0] exp_hi,
	input  wire logic [XLEN-1:0] exp_lo,
	output int                   mismatch_errs,
	output int                   other_errs,
	output int                   pending
);

	int              cycle;
	int              accept_q [$]; // cycle of each live accept
	int              id_q     [$];
	logic [XLEN-1:0] hi_q     [$];
	logic [XLEN-1:0] lo_q     [$];

	task automatic check_result();
		int              acc;
		int              id;
		logic [XLEN-1:0] hi;
		logic [XLEN-1:0] lo;
		if (id_q.size() == 0) begin
			$display("out_valid at cycle %0d with no result expected", cycle);
			other_errs++;
		end else begin
			id = id_q.pop_front();
			hi = hi_q.pop_front();
			lo = lo_q.pop_front();
			if (result_hi !== hi || result_lo !== lo) begin
				$display("mismatch vec%0d: expected %h %h, actual %h %h",
					id, hi, lo, result_hi, result_lo);
				mismatch_errs++;
			end
		end
		if (accept_q.size() == 0) begin
			$display("out_valid at cycle %0d without a matching accept", cycle);
			other_errs++;
		end else begin
			acc = accept_q.pop_front();
			if (cycle != acc + 2) begin
				$display("result at cycle %0d came %0d cycles after its accept, not 2",
					cycle, cycle - acc);
				other_errs++;
			end
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			cycle         = 0;
			mismatch_errs = 0;
			other_errs    = 0;
			accept_q.delete();
			id_q.delete();
			hi_q.delete();
			lo_q.delete();
		end else begin
			cycle++;
			// flush kills whatever was accepted on the previous edge
			if (flush && accept_q.size() > 0 && accept_q[$] == cycle - 1)
				void'(accept_q.pop_back());
			if (mul_valid && !flush)
				accept_q.push_back(cycle);
			if (exp_push) begin
				id_q.push_back(int'(exp_id));
				hi_q.push_back(exp_hi);
				lo_q.push_back(exp_lo);
			end
			if (out_valid)
				check_result();
		end
		pending = accept_q.size() + id_q.size();
	end

endmodule

`default_nettype wire

// File: testbench/tb_booth_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module tb_booth_multiplier;

	import mul_pkg::*;

	localparam int XLEN          = 64;
	localparam int REC_WORDS     = 6; // mode, flush, a, b, hi, lo
	localparam int MAX_RECS      = 64;
	localparam int READY_TIMEOUT = 20;
	localparam int DRAIN_TIMEOUT = 50;

	logic            clk;
	logic            rst_n;
	logic            mul_valid;
	logic            flush;
	logic            mulw;
	sign_sel_t       mul_signed;
	op_word_u        multiplicand;
	op_word_u        multiplier;
	logic            mul_ready;
	logic            out_valid;
	logic [XLEN-1:0] result_hi;
	logic [XLEN-1:0] result_lo;

	logic            exp_push;
	logic [31:0]     exp_id;
	logic [XLEN-1:0] exp_hi;
	logic [XLEN-1:0] exp_lo;
	int              mismatch_errs;
	int              other_errs;
	int              pending;

	logic [63:0]     stim_mem [REC_WORDS*MAX_RECS];
	int              tb_errs;
	int              n_ops;
	logic            ready_ok;

	booth_multiplier #(.XLEN(XLEN)) u_booth_multiplier (
		.clk          (clk),
		.rst_n        (rst_n),
		.mul_valid    (mul_valid),
		.flush        (flush),
		.mulw         (mulw),
		.mul_signed   (mul_signed),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.mul_ready    (mul_ready),
		.out_valid    (out_valid),
		.result_hi    (result_hi),
		.result_lo    (result_lo)
	);

	mul_checker #(.XLEN(XLEN)) u_checker (
		.clk           (clk),
		.rst_n         (rst_n),
		.mul_valid     (mul_valid),
		.flush         (flush),
		.out_valid     (out_valid),
		.result_hi     (result_hi),
		.result_lo     (result_lo),
		.exp_push      (exp_push),
		.exp_id        (exp_id),
		.exp_hi        (exp_hi),
		.exp_lo        (exp_lo),
		.mismatch_errs (mismatch_errs),
		.other_errs    (other_errs),
		.pending       (pending)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic drive_idle();
		mul_valid          = 1'b0;
		flush              = 1'b0;
		mulw               = 1'b0;
		mul_signed         = 2'b00;
		multiplicand.dword = '0;
		multiplier.dword   = '0;
		exp_push           = 1'b0;
		exp_id             = '0;
		exp_hi             = '0;
		exp_lo             = '0;
	endtask

	task automatic wait_ready(output logic ok);
		int cycles;
		ok     = 1'b0;
		cycles = 0;
		while (!ok && cycles < READY_TIMEOUT) begin
			@(posedge clk);
			if (out_valid === 1'b1) begin
				$display("out_valid high before any operation was sent");
				tb_errs++;
			end
			if (mul_ready === 1'b1)
				ok = 1'b1;
			cycles++;
		end
		if (!ok) begin
			$display("timeout: mul_ready did not rise after reset");
			tb_errs++;
		end
		#1;
	endtask

	// one record per cycle, back to back
	task automatic run_stim();
		logic [63:0] mode;
		logic        next_flush;
		int          r;
		r = 0;
		while (r < MAX_RECS && stim_mem[REC_WORDS*r][7:0] != 8'hff) begin
			mode       = stim_mem[REC_WORDS*r];
			next_flush = (r + 1 < MAX_RECS) ? stim_mem[REC_WORDS*(r+1)+1][0] : 1'b0;
			mul_valid          = ~mode[3]; // bit 3 marks an idle cycle
			mulw               = mode[2];
			mul_signed         = mode[1:0];
			flush              = stim_mem[REC_WORDS*r+1][0];
			multiplicand.dword = stim_mem[REC_WORDS*r+2];
			multiplier.dword   = stim_mem[REC_WORDS*r+3];
			// an op followed by a flush dies in stage 1
			exp_push = ~mode[3] & ~flush & ~next_flush;
			exp_id   = 32'(r);
			exp_hi   = stim_mem[REC_WORDS*r+4];
			exp_lo   = stim_mem[REC_WORDS*r+5];
			n_ops++;
			@(posedge clk);
			#1;
			r++;
		end
		drive_idle();
	endtask

	task automatic drain();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (pending != 0 && cycles < DRAIN_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (pending != 0) begin
			$display("timeout: %0d results still outstanding", pending);
			tb_errs++;
		end
	endtask

	initial begin
		tb_errs = 0;
		n_ops   = 0;
		rst_n   = 1'b0;
		drive_idle();
		foreach (stim_mem[i])
			stim_mem[i] = {32'(i), 32'hffff_ffff}; // reads as end marker if the file is missing
		$readmemh("testbench/mul_stim.txt", stim_mem);
		repeat (5) @(posedge clk);
		#1 rst_n = 1'b1;
		wait_ready(ready_ok);
		if (ready_ok)
			run_stim();
		if (n_ops == 0) begin
			$display("no vectors were driven from testbench/mul_stim.txt");
			tb_errs++;
		end
		drain();
		repeat (4) @(posedge clk); // a stray out_valid would show up here
		$display("summary: %0d mismatches, %0d protocol errors, %0d testbench errors",
			mismatch_errs, other_errs, tb_errs);
		if (mismatch_errs + other_errs + tb_errs == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
hw/mul_pkg.sv
hw/booth_encoder.sv
hw/csa_column.sv
hw/product_adder.sv
hw/booth_multiplier.sv
testbench/mul_checker.sv
testbench/tb_booth_multiplier.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the booth multiplier testbench with verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_booth_multiplier
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	-f build.f --top-module "$TOP" -Mdir "$OBJ"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$("./$OBJ/V$TOP")
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the run counts as passed only if the pass line shows up
if printf '%s\n' "$output" | grep -qx 'TEST OK'; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: testbench/mul_stim.txt
// mode flush multiplicand multiplier expected_hi expected_lo, all hex
// mode: bits 1:0 signedness, bit 2 mulw, bit 3 idle cycle, ff ends the list
8 0 0000000000000000 0000000000000000 0000000000000000 0000000000000000
0 0 0000000000000000 0000000000000000 0000000000000000 0000000000000000
0 0 0000000000000003 0000000000000005 0000000000000000 000000000000000f
0 0 ffffffffffffffff ffffffffffffffff fffffffffffffffe 0000000000000001
0 0 ffffffffffffffff 0000000000000002 0000000000000001 fffffffffffffffe
0 0 8000000000000000 8000000000000000 4000000000000000 0000000000000000
0 0 0000000100000000 0000000100000001 0000000000000001 0000000100000000
0 0 00000000ffffffff 00000000ffffffff 0000000000000000 fffffffe00000001
0 0 ffffffffffffffff 0000000100000000 00000000ffffffff ffffffff00000000
0 0 1234567890abcdef 0000000000000100 0000000000000012 34567890abcdef00
3 0 ffffffffffffffff ffffffffffffffff 0000000000000000 0000000000000001
3 0 ffffffffffffffff 0000000000000005 ffffffffffffffff fffffffffffffffb
3 0 8000000000000000 8000000000000000 4000000000000000 0000000000000000
3 0 8000000000000000 ffffffffffffffff 0000000000000000 8000000000000000
3 0 8000000000000000 7fffffffffffffff c000000000000000 8000000000000000
3 0 fffffffffffffffe 0000000000000003 ffffffffffffffff fffffffffffffffa
1 0 ffffffffffffffff ffffffffffffffff ffffffffffffffff 0000000000000001
2 0 ffffffffffffffff 8000000000000000 8000000000000000 8000000000000000
1 0 fffffffffffffffe 8000000000000000 ffffffffffffffff 0000000000000000
7 0 aaaaaaaa00000003 5555555500000007 0000000000000000 0000000000000015
7 0 00000000ffffffff 0000000000000002 ffffffffffffffff fffffffffffffffe
7 0 0000000080000000 0000000080000000 0000000000000000 0000000000000000
7 0 0000000040000000 0000000000000002 0000000000000000 ffffffff80000000
4 0 ffffffff00001000 1234567800000010 0000000000000000 0000000000010000
7 0 123456780000ffff ffffffff0000ffff 0000000000000000 fffffffffffe0001
0 0 0000000000000007 0000000000000009 0000000000000000 000000000000003f
0 0 0000000000000011 0000000000000011 0000000000000000 0000000000000000
0 1 0000000000000022 0000000000000022 0000000000000000 0000000000000000
3 0 fffffffffffffffd 0000000000000007 ffffffffffffffff ffffffffffffffeb
ff 0 0000000000000000 0000000000000000 0000000000000000 0000000000000000
